//--- hw/sourced_pkg.sv
/*
 * Shared widths, TileLink opcodes, message structs and FSM states for the
 * cache response stage. Import it with a wildcard inside a module body and
 * use scoped names in port lists.
 */
package sourced_pkg;

  localparam int WAY_BITS    = 2;
  localparam int SET_BITS    = 4;
  localparam int TAG_BITS    = 6;
  localparam int OFFSET_BITS = 2;
  localparam int SIZE_BITS   = 3;
  localparam int SOURCE_BITS = 3;
  localparam int OP_BITS     = 3;
  localparam int DATA_BITS   = 32;
  localparam int MASK_BITS   = 4;
  localparam int ADDR_BITS   = TAG_BITS + SET_BITS + OFFSET_BITS;

  // channel A request codes
  localparam logic [OP_BITS-1:0] OP_PUTFULL    = 3'd0;
  localparam logic [OP_BITS-1:0] OP_PUTPARTIAL = 3'd1;
  localparam logic [OP_BITS-1:0] OP_GET        = 3'd4;
  localparam logic [OP_BITS-1:0] OP_NONE       = 3'd5; // idle value after reset

  // channel D reply codes
  localparam logic [OP_BITS-1:0] OP_ACCESSACK     = 3'd0;
  localparam logic [OP_BITS-1:0] OP_ACCESSACKDATA = 3'd1;

  localparam logic [SOURCE_BITS-1:0] MEM_SOURCE = 3'd4; // fixed id toward memory

  typedef struct packed {
    logic [OP_BITS-1:0]     opcode;
    logic                   hit;
    logic                   dirty;
    logic [WAY_BITS-1:0]    way;
    logic [SET_BITS-1:0]    set;
    logic [TAG_BITS-1:0]    tag;
    logic [OFFSET_BITS-1:0] offset;
    logic [SIZE_BITS-1:0]   size;
    logic [SOURCE_BITS-1:0] source;
    logic [DATA_BITS-1:0]   data;
    logic [MASK_BITS-1:0]   mask;
  } cache_req_t;

  typedef struct packed {
    logic [WAY_BITS-1:0]  way;
    logic [SET_BITS-1:0]  set;
    logic [MASK_BITS-1:0] mask;
  } bs_adr_t;

  typedef struct packed {
    logic [OP_BITS-1:0]     opcode;
    logic [SIZE_BITS-1:0]   size;
    logic [SOURCE_BITS-1:0] source;
    logic [ADDR_BITS-1:0]   address;
    logic [DATA_BITS-1:0]   data;
  } d_msg_t;

  typedef struct packed {
    logic [OP_BITS-1:0]     opcode;
    logic [SIZE_BITS-1:0]   size;
    logic [SOURCE_BITS-1:0] source;
    logic [ADDR_BITS-1:0]   address;
    logic [DATA_BITS-1:0]   data;
    logic [MASK_BITS-1:0]   mask;
  } a_msg_t;

  typedef enum logic [2:0] {
    IDLE, WAIT_BS, WRITEBACK, ACK, ACK_A_LEFT, ACK_D_LEFT
  } resp_state_t;

  function automatic logic is_put(logic [OP_BITS-1:0] op);
    return (op == OP_PUTFULL) || (op == OP_PUTPARTIAL);
  endfunction

  // read for a get hit, or to fetch the victim of a dirty miss
  function automatic logic need_bs_read(cache_req_t r);
    return ((r.opcode == OP_GET) && r.hit) || (!r.hit && r.dirty);
  endfunction

  function automatic logic need_bs_write(cache_req_t r);
    return is_put(r.opcode) && r.hit;
  endfunction

endpackage

//--- hw/req_stage.sv
/*
 * Request capture for the response stage. Holds one looked-up request,
 * bypasses it in the accept cycle and issues the bank store read and
 * write addresses once per request.
 */
module req_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  sourced_pkg::cache_req_t            req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  logic                               busy_i,
  output logic                               accept_o,
  output sourced_pkg::cache_req_t            cur_req_o,
  output sourced_pkg::bs_adr_t               bs_radr_o,
  output logic                               bs_radr_valid_o,
  input  logic                               bs_radr_ready_i,
  output sourced_pkg::bs_adr_t               bs_wadr_o,
  output logic                               bs_wadr_valid_o,
  input  logic                               bs_wadr_ready_i,
  output logic [sourced_pkg::DATA_BITS-1:0]  bs_wdat_o
);
  import sourced_pkg::*;

  cache_req_t req_q;
  cache_req_t cur_req;
  bs_adr_t    bs_adr;
  logic       need_r;
  logic       need_w;
  logic       rd_sent_q;
  logic       wr_sent_q;
  logic       rd_sent;
  logic       wr_sent;

  assign req_ready_o = !busy_i;
  assign accept_o    = req_valid_i && req_ready_o;

  // opcode comes out of reset as OP_NONE so no bank store valid rises
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '{opcode: OP_NONE, default: '0};
    end else if (accept_o) begin
      req_q <= req_i;
    end
  end

  assign cur_req   = accept_o ? req_i : req_q; // incoming beat wins in accept cycle
  assign cur_req_o = cur_req;

  assign need_r = need_bs_read(cur_req);
  assign need_w = need_bs_write(cur_req);

  // sent flags, so each address goes out once per request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_sent_q <= 1'b0;
      wr_sent_q <= 1'b0;
    end else begin
      if (bs_radr_valid_o && bs_radr_ready_i) begin
        rd_sent_q <= 1'b1;
      end else if (accept_o) begin
        rd_sent_q <= 1'b0;
      end
      if (bs_wadr_valid_o && bs_wadr_ready_i) begin
        wr_sent_q <= 1'b1;
      end else if (accept_o) begin
        wr_sent_q <= 1'b0;
      end
    end
  end

  // a new request sees clear flags in its own accept cycle
  assign rd_sent = accept_o ? 1'b0 : rd_sent_q;
  assign wr_sent = accept_o ? 1'b0 : wr_sent_q;

  assign bs_radr_valid_o = need_r && !rd_sent;
  assign bs_wadr_valid_o = need_w && !wr_sent;

  // both ports address the same line
  assign bs_adr = '{way: cur_req.way, set: cur_req.set, mask: cur_req.mask};

  assign bs_radr_o = bs_adr;
  assign bs_wadr_o = bs_adr;
  assign bs_wdat_o = cur_req.data; // put data rides in the request

endmodule

//--- hw/resp_fsm.sv
/*
 * Response sequencer. Waits for the bank store port a request needs, then
 * drives the D reply to the L1 side, the A write to memory, or a victim
 * writeback with mshr_wait raised. busy goes back to the request stage.
 */
module resp_fsm (
  input  logic                               clk,
  input  logic                               rst_n,
  input  sourced_pkg::cache_req_t            cur_req_i,
  input  logic                               accept_i,
  input  logic                               bs_radr_ready_i,
  input  logic                               bs_wadr_ready_i,
  input  logic [sourced_pkg::DATA_BITS-1:0]  bs_rdat_i,
  output logic                               busy_o,
  output sourced_pkg::d_msg_t                d_o,
  output logic                               d_valid_o,
  input  logic                               d_ready_i,
  output sourced_pkg::a_msg_t                a_o,
  output logic                               a_valid_o,
  input  logic                               a_ready_i,
  output logic                               mshr_wait_o
);
  import sourced_pkg::*;

  resp_state_t          state_q;
  logic                 pending_q;
  cache_req_t           fin_q;
  logic                 port_rdy;
  logic                 cur_wb;
  logic                 fin_get;
  logic                 fin_put_miss;
  logic                 fin_wb;
  logic                 d_fire;
  logic                 a_fire;
  logic [ADDR_BITS-1:0] addr;

  // bank store port for the request being dispatched
  always_comb begin
    if (need_bs_read(cur_req_i)) begin
      port_rdy = bs_radr_ready_i;
    end else if (need_bs_write(cur_req_i)) begin
      port_rdy = bs_wadr_ready_i;
    end else begin
      port_rdy = 1'b1; // clean miss touches no bank
    end
  end

  assign cur_wb = !cur_req_i.hit && cur_req_i.dirty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      pending_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE, WAIT_BS: begin
          if (accept_i || pending_q) begin
            if (port_rdy) begin
              state_q   <= cur_wb ? WRITEBACK : ACK;
              pending_q <= 1'b0;
            end else begin
              state_q   <= WAIT_BS; // hold it, bank store busy
              pending_q <= 1'b1;
            end
          end
        end
        WRITEBACK: begin
          if (a_fire) state_q <= IDLE;
        end
        ACK: begin
          if (fin_put_miss) begin
            // write-through, D and A may finish in any order
            if (d_fire && a_fire) begin
              state_q <= IDLE;
            end else if (d_fire) begin
              state_q <= ACK_A_LEFT;
            end else if (a_fire) begin
              state_q <= ACK_D_LEFT;
            end
          end else if (d_fire) begin
            state_q <= IDLE;
          end
        end
        ACK_A_LEFT: begin
          if (a_fire) state_q <= IDLE;
        end
        ACK_D_LEFT: begin
          if (d_fire) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // final copy, follows the held request
  always_ff @(posedge clk) begin
    fin_q <= cur_req_i;
  end

  assign fin_get      = fin_q.opcode == OP_GET;
  assign fin_put_miss = is_put(fin_q.opcode) && !fin_q.hit;
  assign fin_wb       = !fin_q.hit && fin_q.dirty;

  assign busy_o      = state_q != IDLE;
  assign mshr_wait_o = state_q == WRITEBACK; // blocks misses on the victim way

  assign d_valid_o = (state_q == ACK) || (state_q == ACK_D_LEFT);
  assign a_valid_o = (state_q == WRITEBACK) || (state_q == ACK_A_LEFT) ||
                     ((state_q == ACK) && fin_put_miss);

  assign d_fire = d_valid_o && d_ready_i;
  assign a_fire = a_valid_o && a_ready_i;

  assign addr = {fin_q.tag, fin_q.set, fin_q.offset};

  always_comb begin
    d_o.opcode  = fin_get ? OP_ACCESSACKDATA : OP_ACCESSACK;
    d_o.size    = fin_q.size;
    d_o.source  = fin_q.source;
    d_o.address = addr;
    if (fin_get) begin
      d_o.data = fin_q.hit ? bs_rdat_i : fin_q.data; // miss carries refill data
    end else begin
      d_o.data = '0;
    end
  end

  always_comb begin
    a_o.opcode  = OP_PUTFULL;
    a_o.size    = fin_q.size;
    a_o.source  = MEM_SOURCE;
    a_o.address = addr;
    a_o.data    = fin_wb ? bs_rdat_i : fin_q.data; // victim word on writeback
    a_o.mask    = fin_q.mask;
  end

endmodule

//--- hw/sourced_top.sv
/*
 * Top of the cache response stage. Connects the request stage, which owns
 * the bank store address ports, to the response FSM, which owns the D and
 * A channels and mshr_wait.
 */
module sourced_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  sourced_pkg::cache_req_t            req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  output sourced_pkg::bs_adr_t               bs_radr_o,
  output logic                               bs_radr_valid_o,
  input  logic                               bs_radr_ready_i,
  input  logic [sourced_pkg::DATA_BITS-1:0]  bs_rdat_i,
  output sourced_pkg::bs_adr_t               bs_wadr_o,
  output logic                               bs_wadr_valid_o,
  input  logic                               bs_wadr_ready_i,
  output logic [sourced_pkg::DATA_BITS-1:0]  bs_wdat_o,
  output sourced_pkg::d_msg_t                d_o,
  output logic                               d_valid_o,
  input  logic                               d_ready_i,
  output sourced_pkg::a_msg_t                a_o,
  output logic                               a_valid_o,
  input  logic                               a_ready_i,
  output logic                               mshr_wait_o
);
  import sourced_pkg::*;

  cache_req_t cur_req;
  logic       accept;
  logic       busy;

  req_stage req_stage_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .busy_i          (busy),
    .accept_o        (accept),
    .cur_req_o       (cur_req),
    .bs_radr_o       (bs_radr_o),
    .bs_radr_valid_o (bs_radr_valid_o),
    .bs_radr_ready_i (bs_radr_ready_i),
    .bs_wadr_o       (bs_wadr_o),
    .bs_wadr_valid_o (bs_wadr_valid_o),
    .bs_wadr_ready_i (bs_wadr_ready_i),
    .bs_wdat_o       (bs_wdat_o)
  );

  resp_fsm resp_fsm_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .cur_req_i       (cur_req),
    .accept_i        (accept),
    .bs_radr_ready_i (bs_radr_ready_i),
    .bs_wadr_ready_i (bs_wadr_ready_i),
    .bs_rdat_i       (bs_rdat_i),
    .busy_o          (busy),
    .d_o             (d_o),
    .d_valid_o       (d_valid_o),
    .d_ready_i       (d_ready_i),
    .a_o             (a_o),
    .a_valid_o       (a_valid_o),
    .a_ready_i       (a_ready_i),
    .mshr_wait_o     (mshr_wait_o)
  );

endmodule

//--- tb/sourced_sva.sv
/*
 * Assertions bound into the response FSM. Checks that D and A payloads
 * hold under back-pressure, that busy only drops after a closing
 * handshake and that mshr_wait holds until the writeback is taken.
 */
module sourced_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      busy_i,
  input sourced_pkg::d_msg_t       d_i,
  input logic                      d_valid_i,
  input logic                      d_ready_i,
  input sourced_pkg::a_msg_t       a_i,
  input logic                      a_valid_i,
  input logic                      a_ready_i,
  input logic                      mshr_wait_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // stalled D reply keeps valid and payload
  d_hold: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_i))
    else $error("D payload changed under back-pressure");

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    a_valid_i && !a_ready_i |=> a_valid_i && $stable(a_i))
    else $error("A payload changed under back-pressure");

  // req_ready_o comes back only after a D or A handshake
  busy_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy_i) |-> $past((d_valid_i && d_ready_i) || (a_valid_i && a_ready_i)))
    else $error("busy dropped without a closing handshake");

  mshr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mshr_wait_i && !(a_valid_i && a_ready_i) |=> mshr_wait_i)
    else $error("mshr_wait dropped before the writeback was taken");

endmodule

//--- tb/sourced_tb.sv
/*
 * Testbench for the cache response stage. Reads requests and expected
 * reply data from the pattern file, models the bank store and random
 * ready on every channel, and checks the D, A and bank store traffic.
 */
module sourced_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import sourced_pkg::*;

  localparam int NUM_PAT = 16;
  localparam int FIELDS  = 13; // words per pattern line
  localparam int TIMEOUT = 200;

  logic clk;
  logic rst_n;
  cache_req_t req;
  logic req_valid;
  logic req_ready_o;
  bs_adr_t bs_radr_o;
  logic bs_radr_valid_o;
  logic bs_radr_ready;
  logic [DATA_BITS-1:0] bs_rdat;
  bs_adr_t bs_wadr_o;
  logic bs_wadr_valid_o;
  logic bs_wadr_ready;
  logic [DATA_BITS-1:0] bs_wdat_o;
  d_msg_t d_o;
  logic d_valid_o;
  logic d_ready;
  a_msg_t a_o;
  logic a_valid_o;
  logic a_ready;
  logic mshr_wait_o;

  logic [31:0] pat_mem [0:NUM_PAT*FIELDS-1];
  integer seed = 86212;
  int mismatches = 0;
  int timeouts = 0;
  int other_errors = 0;
  logic cur_wb = 1'b0; // current request evicts a dirty victim

  bs_adr_t rd_q[$];
  bs_adr_t wr_q[$];
  logic [DATA_BITS-1:0] wdat_q[$];
  d_msg_t d_q[$];
  a_msg_t a_q[$];

  sourced_top sourced_top_i (
    .clk (clk), .rst_n (rst_n),
    .req_i (req), .req_valid_i (req_valid), .req_ready_o (req_ready_o),
    .bs_radr_o (bs_radr_o), .bs_radr_valid_o (bs_radr_valid_o),
    .bs_radr_ready_i (bs_radr_ready), .bs_rdat_i (bs_rdat),
    .bs_wadr_o (bs_wadr_o), .bs_wadr_valid_o (bs_wadr_valid_o),
    .bs_wadr_ready_i (bs_wadr_ready), .bs_wdat_o (bs_wdat_o),
    .d_o (d_o), .d_valid_o (d_valid_o), .d_ready_i (d_ready),
    .a_o (a_o), .a_valid_o (a_valid_o), .a_ready_i (a_ready),
    .mshr_wait_o (mshr_wait_o)
  );

  bind resp_fsm sourced_sva sva_i (
    .clk (clk), .rst_n (rst_n), .busy_i (busy_o),
    .d_i (d_o), .d_valid_i (d_valid_o), .d_ready_i (d_ready_i),
    .a_i (a_o), .a_valid_i (a_valid_o), .a_ready_i (a_ready_i),
    .mshr_wait_i (mshr_wait_o)
  );

  always #2 clk = !clk;

  // bank word is a tag of way and set
  assign bs_rdat = {24'hC0DE00, 2'b00, bs_radr_o.way, bs_radr_o.set};

  // new ready values on the falling edge, handshakes sampled mid low phase
  always @(negedge clk) begin
    bs_radr_ready = ($random(seed) & 3) != 0;
    bs_wadr_ready = ($random(seed) & 3) != 0;
    d_ready       = ($random(seed) & 3) != 0;
    a_ready       = ($random(seed) & 3) != 0;
    #1;
    if (rst_n) begin
      if (bs_radr_valid_o && bs_radr_ready) rd_q.push_back(bs_radr_o);
      if (bs_wadr_valid_o && bs_wadr_ready) begin
        wr_q.push_back(bs_wadr_o);
        wdat_q.push_back(bs_wdat_o);
      end
      if (d_valid_o && d_ready) d_q.push_back(d_o);
      if (a_valid_o && a_ready) a_q.push_back(a_o);
      if (cur_wb && a_valid_o && !mshr_wait_o) begin
        other_errors++;
        $display("mshr_wait_o was low while the victim writeback was pending");
      end
      if (mshr_wait_o && !cur_wb) begin
        other_errors++;
        $display("mshr_wait_o was high for a request without a dirty victim");
      end
    end
  end

  task automatic check_d(input d_msg_t got, input d_msg_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch d_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_a(input a_msg_t got, input a_msg_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch a_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_bs(input string name, input bs_adr_t got, input bs_adr_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] got,
                            input logic [DATA_BITS-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatches++;
      $display("Mismatch %s handshakes: got %h expected %h", name, got, exp);
    end
  endtask

  // wait on the falling edge until req_ready_o is high
  task automatic wait_ready(input int idx, output bit ok);
    int cnt;
    cnt = 0;
    while (!req_ready_o && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    ok = req_ready_o;
    if (!ok) begin
      timeouts++;
      $display("timeout: request %0d never released req_ready_o", idx);
    end
  endtask

  task automatic run_pattern(input int idx, output bit ok);
    int b;
    cache_req_t r;
    d_msg_t exp_d;
    a_msg_t exp_a;
    bit is_get;
    bit put;
    b = idx * FIELDS;
    r.opcode = pat_mem[b][OP_BITS-1:0];
    r.hit    = pat_mem[b+1][0];
    r.dirty  = pat_mem[b+2][0];
    r.way    = pat_mem[b+3][WAY_BITS-1:0];
    r.set    = pat_mem[b+4][SET_BITS-1:0];
    r.tag    = pat_mem[b+5][TAG_BITS-1:0];
    r.offset = pat_mem[b+6][OFFSET_BITS-1:0];
    r.size   = pat_mem[b+7][SIZE_BITS-1:0];
    r.source = pat_mem[b+8][SOURCE_BITS-1:0];
    r.data   = pat_mem[b+9];
    r.mask   = pat_mem[b+10][MASK_BITS-1:0];
    is_get = r.opcode == OP_GET;
    put    = (r.opcode == OP_PUTFULL) || (r.opcode == OP_PUTPARTIAL);
    exp_d = '{opcode: is_get ? OP_ACCESSACKDATA : OP_ACCESSACK, size: r.size,
              source: r.source, address: {r.tag, r.set, r.offset}, data: pat_mem[b+11]};
    exp_a = '{opcode: OP_PUTFULL, size: r.size, source: MEM_SOURCE,
              address: {r.tag, r.set, r.offset}, data: pat_mem[b+12], mask: r.mask};
    rd_q.delete();
    wr_q.delete();
    wdat_q.delete();
    d_q.delete();
    a_q.delete();
    wait_ready(idx, ok);
    if (ok) begin
      cur_wb    = !r.hit && r.dirty;
      req       = r;
      req_valid = 1'b1;
      @(posedge clk); // accepted here
      @(negedge clk);
      req_valid = 1'b0;
      check_flag("req_ready_o", req_ready_o, 1'b0);
      wait_ready(idx, ok);
    end
    if (ok) begin
      check_count("bs read", rd_q.size(), ((is_get && r.hit) || cur_wb) ? 1 : 0);
      check_count("bs write", wr_q.size(), (put && r.hit) ? 1 : 0);
      check_count("d", d_q.size(), cur_wb ? 0 : 1);
      check_count("a", a_q.size(), (cur_wb || (put && !r.hit)) ? 1 : 0);
      if (rd_q.size() == 1) check_bs("bs_radr_o", rd_q[0], '{r.way, r.set, r.mask});
      if (wr_q.size() == 1) begin
        check_bs("bs_wadr_o", wr_q[0], '{r.way, r.set, r.mask});
        check_word("bs_wdat_o", wdat_q[0], r.data);
      end
      if (d_q.size() == 1) check_d(d_q[0], exp_d);
      if (a_q.size() == 1) check_a(a_q[0], exp_a);
    end
  endtask

  initial begin
    bit ok;
    clk = 1'b0;
    rst_n = 1'b0;
    req = '0;
    req_valid = 1'b0;
    bs_radr_ready = 1'b0;
    bs_wadr_ready = 1'b0;
    d_ready = 1'b0;
    a_ready = 1'b0;
    $readmemh("tb/sourced_patterns.txt", pat_mem);
    repeat (5) @(posedge clk);
    @(negedge clk);
    if (d_valid_o || a_valid_o || bs_radr_valid_o || bs_wadr_valid_o || mshr_wait_o ||
        !req_ready_o) begin
      other_errors++;
      $display("outputs not in their idle state during reset");
    end
    rst_n = 1'b1;
    ok = 1'b1;
    for (int i = 0; i < NUM_PAT && ok; i++) begin
      run_pattern(i, ok);
    end
    $display("errors: mismatch %0d, timeout %0d, other %0d", mismatches, timeouts,
             other_errors);
    if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb/sourced_patterns.txt
// op hit dirty way set tag offset size source data mask exp_d_data exp_a_data
// hex words, one request per line
4 1 0 1 3 2A 1 2 1 11111111 F C0DE0013 0
4 1 1 2 5 15 0 2 2 22222222 F C0DE0025 0
4 0 0 0 7 3C 2 2 3 CAFE0001 F CAFE0001 0
0 1 0 3 F 01 0 2 0 DEADBEEF F 0 0
1 1 0 0 2 3F 3 0 5 000000A5 1 0 0
0 0 0 1 9 12 1 2 6 12345678 F 0 12345678
1 0 0 2 A 20 2 1 7 0000BEEF 3 0 0000BEEF
4 0 1 3 C 0B 0 2 1 55555555 F 0 C0DE003C
0 0 1 0 1 07 1 2 2 66666666 F 0 C0DE0001
4 1 0 3 0 2F 3 2 4 77777777 F C0DE0030 0
4 0 0 1 E 11 0 2 5 0BADF00D F 0BADF00D 0
1 1 1 2 6 33 1 1 6 0000FACE C 0 0
0 0 0 3 8 0A 0 2 0 A5A5A5A5 F 0 A5A5A5A5
1 0 1 1 B 2C 2 0 3 000000EE 2 0 C0DE001B
4 1 0 0 0 00 0 2 7 88888888 F C0DE0000 0
0 1 0 1 D 3E 3 2 1 99999999 F 0 0

//--- sources.f
hw/sourced_pkg.sv
hw/req_stage.sv
hw/resp_fsm.sv
hw/sourced_top.sv
tb/sourced_sva.sv
tb/sourced_tb.sv

//--- Makefile
# Verilator build for the cache response stage testbench

VERILATOR ?= verilator
TOP       ?= sourced_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
